// File: design/pci_lite_pkg.sv
//////////////////////////////////////////////////
// pci lite shared definitions
// bus widths, command codes, target window,
// abort timing and the initiator state type
//////////////////////////////////////////////////

package pci_lite_pkg;

    localparam int ad_width    = 32;   // address/data bus
    localparam int cbe_width   = 4;    // command field
    localparam int n_req       = 5;    // arbiter lines, 0 is local, 4 wins
    localparam int count_width = 3;    // burst length field, n means n+1 words

    typedef logic [ad_width-1:0]  ad_t;
    typedef logic [cbe_width-1:0] cbe_t;

    localparam cbe_t cmd_write = 4'b1000;
    localparam cbe_t cmd_read  = 4'b0000;

    // target memory and its address window
    localparam int  mem_words   = 10;
    localparam int  idx_width   = 4;        // holds 0..mem_words-1
    localparam ad_t target_base = 32'd10;   // first claimed address

    // master abort after this many cycles without devsel
    localparam int devsel_timeout = 4;
    localparam int tmo_width      = 3;

    typedef enum logic [2:0] {
        st_idle,
        st_request,
        st_address,
        st_data,
        st_finish
    } bus_state_t;

endpackage

// File: design/pci_bus_if.sv
//////////////////////////////////////////////////
// shared bus between initiator and target
// one signal per direction instead of tristates
//////////////////////////////////////////////////
`timescale 1ns/1ns

interface pci_bus_if import pci_lite_pkg::*; ();

    logic frame;     // address phase and all but last data phase
    logic irdy;      // initiator ready, high in data phases
    cbe_t cbe;       // command during address phase
    ad_t  ad_init;   // address, then write data
    logic devsel;    // target claim
    logic trdy;      // target ready
    ad_t  ad_targ;   // read data from target

    modport initiator (
        output frame, irdy, cbe, ad_init,
        input  devsel, trdy, ad_targ
    );

    modport target (
        output devsel, trdy, ad_targ,
        input  frame, irdy, cbe, ad_init
    );

    // arbiter only needs to know when the bus is idle
    modport monitor (
        input frame, irdy
    );

endinterface

// File: design/bus_arbiter.sv
//////////////////////////////////////////////////
// fixed priority bus arbiter
// registered one-hot grant, highest index wins,
// grant only moves while the bus is idle
//////////////////////////////////////////////////
`timescale 1ns/1ns

module bus_arbiter import pci_lite_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [n_req-1:0] req,
    output logic [n_req-1:0] gnt,
    pci_bus_if.monitor       bus
);

    logic [n_req-1:0] next_gnt;
    logic             bus_idle;

    assign bus_idle = !bus.frame && !bus.irdy;   // no phase in progress

    // later index overwrites earlier, so the top request wins
    always_comb
    begin
        next_gnt = '0;
        for (int i = 0; i < n_req; i++)
        begin
            if (req[i])
            begin
                next_gnt    = '0;
                next_gnt[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            gnt <= '0;
        else if (bus_idle)
            gnt <= next_gnt;   // zero when nobody asks
        // busy bus keeps the current owner
    end

endmodule

// File: design/bus_initiator.sv
//////////////////////////////////////////////////
// burst initiator
// requests the bus, drives address phase and
// 1 to 8 data phases, write or read, and ends
// with a master abort when devsel never comes
//////////////////////////////////////////////////
`timescale 1ns/1ns

module bus_initiator import pci_lite_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  logic                   write,
    input  ad_t                    addr,
    input  logic [count_width-1:0] count,
    input  ad_t                    wdata,
    output logic                   word_taken,
    output ad_t                    rdata,
    output logic                   rdata_valid,
    output logic                   busy,
    output logic                   done,
    output logic                   abort,
    output logic                   local_req,
    input  logic                   local_gnt,
    pci_bus_if.initiator           bus
);

    bus_state_t             state;
    logic                   write_q;      // burst direction
    ad_t                    addr_q;       // target address
    logic [count_width-1:0] words_left;   // zero on the last data phase
    logic [tmo_width-1:0]   tmo_cnt;      // cycles without devsel
    logic                   abort_q;
    logic                   last_phase;
    logic                   word_moved;
    logic                   can_start;

    // finish counts as free so a new start right after done is kept
    assign can_start  = (state == st_idle) || (state == st_finish);
    assign last_phase = (words_left == '0);
    assign word_moved = (state == st_data) && bus.trdy;   // irdy is high in data

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state       <= st_idle;
            write_q     <= 1'b0;
            words_left  <= '0;
            tmo_cnt     <= '0;
            abort_q     <= 1'b0;
            rdata_valid <= 1'b0;
        end
        else
        begin
            rdata_valid <= word_moved && !write_q;   // one cycle behind the move
            case (state)
                st_idle, st_finish:
                begin
                    if (start)
                    begin
                        state      <= st_request;
                        write_q    <= write;
                        words_left <= count;
                    end
                    else
                        state <= st_idle;
                end
                st_request:
                    if (local_gnt)
                        state <= st_address;   // wait as long as arbiter says no
                st_address:
                begin
                    state   <= st_data;
                    tmo_cnt <= '0;      // abort timer starts here
                    abort_q <= 1'b0;
                end
                st_data:
                begin
                    if (word_moved)
                    begin
                        if (last_phase)
                            state <= st_finish;
                        else
                            words_left <= words_left - 1'b1;
                    end
                    else if (!bus.devsel)
                    begin
                        // nobody claimed the address
                        if (tmo_cnt == tmo_width'(devsel_timeout - 1))
                        begin
                            state   <= st_finish;
                            abort_q <= 1'b1;
                        end
                        else
                            tmo_cnt <= tmo_cnt + 1'b1;
                    end
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // payload, only meaningful with rdata_valid
    always_ff @(posedge clk)
    begin
        if (start && can_start)
            addr_q <= addr;
        if (word_moved && !write_q)
            rdata <= bus.ad_targ;
    end

    assign busy       = (state == st_request) || (state == st_address) || (state == st_data);
    assign local_req  = (state == st_request);   // drops in the address phase
    assign done       = (state == st_finish);
    assign abort      = done && abort_q;
    assign word_taken = word_moved && write_q;   // outside moves to the next word

    // frame falls on the last data phase
    assign bus.frame   = (state == st_address) || ((state == st_data) && !last_phase);
    assign bus.irdy    = (state == st_data);
    assign bus.cbe     = (state == st_address) ? (write_q ? cmd_write : cmd_read) : '0;
    assign bus.ad_init = (state == st_address)           ? addr_q :
                         ((state == st_data) && write_q) ? wdata  : '0;

endmodule

// File: design/target_memory.sv
//////////////////////////////////////////////////
// ten word memory target
// claims its address window, answers with devsel
// and trdy, no wait states, index wraps at 9
//////////////////////////////////////////////////
`timescale 1ns/1ns

module target_memory import pci_lite_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    pci_bus_if.target bus
);

    ad_t                  mem [mem_words];
    logic [idx_width-1:0] idx;        // current word
    logic [idx_width-1:0] idx_next;
    logic                 write_q;    // command of the claimed burst
    logic                 addr_phase;
    logic                 in_window;
    logic                 known_cmd;
    ad_t                  offset;
    logic                 word_moved;

    assign addr_phase = bus.frame && !bus.irdy;   // frame without irdy
    assign offset     = bus.ad_init - target_base;
    assign in_window  = (bus.ad_init >= target_base) &&
                        (bus.ad_init < target_base + ad_t'(mem_words));
    assign known_cmd  = (bus.cbe == cmd_write) || (bus.cbe == cmd_read);
    assign word_moved = bus.devsel && bus.irdy && bus.trdy;

    // wrap from the last word back to 0
    assign idx_next = (idx == idx_width'(mem_words - 1)) ? '0 : idx + 1'b1;

    // memory is cleared so a first read sees zeros
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bus.devsel  <= 1'b0;
            bus.trdy    <= 1'b0;
            bus.ad_targ <= '0;
            idx         <= '0;
            write_q     <= 1'b0;
            for (int i = 0; i < mem_words; i++)
                mem[i] <= '0;
        end
        else if (addr_phase && in_window && known_cmd)
        begin
            bus.devsel  <= 1'b1;   // claim, ready on the next cycle
            bus.trdy    <= 1'b1;
            write_q     <= (bus.cbe == cmd_write);
            idx         <= offset[idx_width-1:0];
            bus.ad_targ <= mem[offset[idx_width-1:0]];   // first read word
        end
        else if (word_moved)
        begin
            if (write_q)
                mem[idx] <= bus.ad_init;
            idx         <= idx_next;
            bus.ad_targ <= mem[idx_next];   // next read word, ignored on writes
            if (!bus.frame)
            begin
                bus.devsel <= 1'b0;   // last word gone, release
                bus.trdy   <= 1'b0;
            end
        end
    end

endmodule

// File: design/pci_lite_top.sv
//////////////////////////////////////////////////
// pci lite top level
// arbiter, burst initiator and memory target on
// one shared bus, four spare request/grant pins
//////////////////////////////////////////////////
`timescale 1ns/1ns

module pci_lite_top import pci_lite_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  logic                   write,
    input  ad_t                    addr,
    input  logic [count_width-1:0] count,
    input  ad_t                    wdata,
    output logic                   word_taken,
    output ad_t                    rdata,
    output logic                   rdata_valid,
    output logic                   busy,
    output logic                   done,
    output logic                   abort,
    input  logic [n_req-2:0]       ext_req,
    output logic [n_req-2:0]       ext_gnt
);

    logic             local_req;
    logic             local_gnt;
    logic [n_req-1:0] arb_req;
    logic [n_req-1:0] arb_gnt;

    pci_bus_if bus ();

    // local initiator sits on line 0, lowest priority
    assign arb_req   = {ext_req, local_req};
    assign local_gnt = arb_gnt[0];
    assign ext_gnt   = arb_gnt[n_req-1:1];

    bus_arbiter u_arbiter (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (arb_req),
        .gnt    (arb_gnt),
        .bus    (bus.monitor)
    );

    bus_initiator u_initiator (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .write       (write),
        .addr        (addr),
        .count       (count),
        .wdata       (wdata),
        .word_taken  (word_taken),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .busy        (busy),
        .done        (done),
        .abort       (abort),
        .local_req   (local_req),
        .local_gnt   (local_gnt),
        .bus         (bus.initiator)
    );

    target_memory u_target (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (bus.target)
    );

endmodule

// File: test/pci_lite_assertions.sv
//////////////////////////////////////////////////
// bus protocol checks for the pci lite top
// grant encoding, target handshake and the
// order of address and data phases
//////////////////////////////////////////////////
`timescale 1ns/1ns

module pci_lite_assertions import pci_lite_pkg::*; (
    input logic             clk,
    input logic             arst_n,
    input logic             frame,
    input logic             irdy,
    input logic             devsel,
    input logic             trdy,
    input logic             local_gnt,
    input logic [n_req-1:0] gnt
);

    // at most one owner at a time
    grant_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(gnt))
        else $error("arbiter grant has more than one bit set");

    trdy_claimed: assert property (@(posedge clk) disable iff (!arst_n) trdy |-> devsel)
        else $error("trdy high without devsel");

    // data phase must follow an address phase (frame without irdy)
    irdy_after_addr: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(irdy) |-> $past(frame && !irdy))
        else $error("irdy rose without an address phase before it");

    frame_granted: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(frame) |-> local_gnt)
        else $error("frame rose while the initiator held no grant");

endmodule

bind pci_lite_top pci_lite_assertions u_assertions (
    .clk       (clk),
    .arst_n    (arst_n),
    .frame     (bus.frame),
    .irdy      (bus.irdy),
    .devsel    (bus.devsel),
    .trdy      (bus.trdy),
    .local_gnt (local_gnt),
    .gnt       (arb_gnt)
);

// File: test/pci_lite_tb.sv
//////////////////////////////////////////////////
// pci lite testbench
// random write/read/abort bursts and arbiter
// hold-off, checked against a memory model
//////////////////////////////////////////////////
`timescale 1ns/1ns

module pci_lite_tb import pci_lite_pkg::*; ();

    logic                   clk;
    logic                   arst_n;
    logic                   start;
    logic                   write;
    ad_t                    addr;
    logic [count_width-1:0] count;
    ad_t                    wdata;
    logic                   word_taken;
    ad_t                    rdata;
    logic                   rdata_valid;
    logic                   busy;
    logic                   done;
    logic                   abort;
    logic [n_req-2:0]       ext_req;
    logic [n_req-2:0]       ext_gnt;
    ad_t                    model [mem_words];   // expected target memory
    logic [31:0]            rng_state;
    int                     n_random     = 40;   // random bursts after the directed ones
    int                     burst_cycles = 30;   // worst case incl. hold-off and abort

    pci_lite_top uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // watchdog, budget from burst count
    initial
    begin
        #((n_random + 8) * burst_cycles * 100 + 250 * 100);
        $display("Timeout: the bursts did not complete within the cycle budget");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    function automatic ad_t next_random();
        rng_state = rng_state ^ (rng_state << 13);   // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // any address the target must not claim
    function automatic ad_t outside_address();
        ad_t r;
        r = next_random();
        return r[0] ? (r % target_base) : (r | 32'h100);
    endfunction

    // highest set bit wins, searched from the top
    function automatic logic [n_req-2:0] top_request(input logic [n_req-2:0] r);
        logic [n_req-2:0] g;
        g = '0;
        for (int i = n_req - 2; i >= 0; i--)
        begin
            if (r[i])
            begin
                g[i] = 1'b1;
                break;
            end
        end
        return g;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // one burst from start to done, hold = cycles the ext request keeps the bus
    task automatic run_burst(input logic wr, input ad_t a, input int cnt, input int hold);
        ad_t  words [$];
        ad_t  noise;
        int   ptr;
        int   n_taken;
        int   n_valid;
        int   idx;
        logic in_win;
        logic finished;
        in_win = (a >= target_base) && (a < target_base + mem_words);
        idx    = in_win ? int'(a - target_base) : 0;   // offset picks the word
        for (int i = 0; i <= cnt; i++)
            words.push_back(next_random());
        ptr      = 0;
        n_taken  = 0;
        n_valid  = 0;
        finished = 1'b0;
        start    = 1'b1;
        write    = wr;
        addr     = a;
        count    = cnt[count_width-1:0];
        wdata    = words[0];
        @(negedge clk);
        start = 1'b0;
        noise = next_random();   // scramble inputs, only start captures them
        write = noise[0];
        addr  = noise;
        count = noise[count_width:1];
        for (int h = 0; h < hold; h++)
        begin
            check_value("busy", 1, busy);   // grant held by the external line
            check_value("done", 0, done);
            check_value("ext_gnt", top_request(ext_req), ext_gnt);
            @(negedge clk);
        end
        if (hold > 0)
            ext_req = '0;
        while (!finished)
        begin
            if (ptr <= cnt)
                wdata = words[ptr];   // word for the next edge
            if (word_taken)
            begin
                if (ptr <= cnt)
                    model[idx] = words[ptr];
                idx = (idx + 1) % mem_words;
                ptr++;
                n_taken++;
            end
            if (rdata_valid)
            begin
                check_value("rdata", model[idx], rdata);
                idx = (idx + 1) % mem_words;
                n_valid++;
            end
            if (done)
            begin
                check_value("abort", !in_win, abort);
                check_value("busy", 0, busy);   // falls together with done
                finished = 1'b1;
            end
            else
                @(negedge clk);
        end
        check_value("word_taken pulses", (wr && in_win) ? cnt + 1 : 0, n_taken);
        check_value("rdata_valid pulses", (!wr && in_win) ? cnt + 1 : 0, n_valid);
    endtask

    // two 8 word reads cover every index, second one wraps
    task automatic read_all();
        run_burst(1'b0, target_base, 7, 0);
        run_burst(1'b0, target_base + 8, 7, 0);
    endtask

    task automatic arbitrated_burst();
        int b;
        b          = int'(next_random() % 4);
        ext_req    = '0;
        ext_req[b] = 1'b1;
        @(negedge clk);
        check_value("ext_gnt", top_request(ext_req), ext_gnt);
        run_burst(next_random() % 2 == 1, target_base + next_random() % mem_words,
                  int'(next_random() % 8), 2 + int'(next_random() % 6));
    endtask

    // idle bus, grant follows requests one edge later
    task automatic grant_sweep(input int cycles);
        logic [n_req-2:0] prev;
        ad_t              r;
        @(negedge clk);
        for (int i = 0; i < cycles; i++)
        begin
            r       = next_random();
            ext_req = r[n_req-2:0];
            prev    = ext_req;
            @(negedge clk);
            check_value("ext_gnt", top_request(prev), ext_gnt);
        end
        ext_req = '0;
        @(negedge clk);
    endtask

    initial
    begin
        ad_t r;
        rng_state = 32'd37997;
        arst_n    = 1'b0;
        start     = 1'b0;
        write     = 1'b0;
        addr      = '0;
        count     = '0;
        wdata     = '0;
        ext_req   = '0;
        for (int i = 0; i < mem_words; i++)
            model[i] = '0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("done", 0, done);
        check_value("abort", 0, abort);
        check_value("word_taken", 0, word_taken);
        check_value("rdata_valid", 0, rdata_valid);
        check_value("ext_gnt", 0, ext_gnt);
        read_all();   // memory starts at zero
        run_burst(1'b1, target_base + 3, 7, 0);   // wraps 9 to 0
        run_burst(1'b0, target_base + 3, 7, 0);
        run_burst(1'b1, outside_address(), 3, 0);   // master abort
        arbitrated_burst();
        for (int n = 0; n < n_random; n++)
        begin
            r = next_random();
            case (r % 8)
                0:       run_burst(r[8], outside_address(), int'(next_random() % 8), 0);
                1:       arbitrated_burst();
                default: run_burst(r[8], target_base + next_random() % mem_words,
                                   int'(next_random() % 8), 0);
            endcase
        end
        grant_sweep(20);
        read_all();   // aborted writes must leave no trace
        $display("Verification passed");
        $finish;
    end

endmodule

// File: project.f
design/pci_lite_pkg.sv
design/pci_bus_if.sv
design/bus_arbiter.sv
design/bus_initiator.sv
design/target_memory.sv
design/pci_lite_top.sv
test/pci_lite_assertions.sv
test/pci_lite_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = pci_lite_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
